// File: Makefile
# Verilator build and run of the control section testbench

VERILATOR ?= verilator
TOP ?= cpu_ctrl_tb
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f sources.f
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/bus_ctrl.sv
//********************
// Memory bus strobes, status pins and address source
//********************
`timescale 1ns/1ps

module bus_ctrl (
	input cpu_ctrl_pkg::mcycle_e mcycle,
	input cpu_ctrl_pkg::tstate_e tstate,
	input cpu_ctrl_pkg::cycle_idx_t cycle_idx,
	input cpu_ctrl_pkg::group_e group,
	input cpu_ctrl_pkg::byte_t opcode,
	output logic ale,
	output logic rd_n,
	output logic wr_n,
	output logic s1,
	output logic s0,
	output cpu_ctrl_pkg::addr_src_e addr_src
);
	import cpu_ctrl_pkg::*;

	logic strobe_window;

	assign strobe_window = (tstate == t2) || (tstate == t3);

	assign ale = (tstate == t1);
	assign rd_n = ~(strobe_window && (mcycle == mc_fetch || mcycle == mc_read));
	assign wr_n = ~(strobe_window && mcycle == mc_write);

	always_comb begin
		if (tstate == t_idle) begin
			{s1, s0} = 2'b00;	// Reset or halt
		end else begin
			case (mcycle)
				mc_fetch: {s1, s0} = 2'b11;
				mc_read: {s1, s0} = 2'b10;
				mc_write: {s1, s0} = 2'b01;
				default: {s1, s0} = 2'b00;
			endcase
		end
	end

	always_comb begin
		addr_src = as_pc;	// Fetch and immediate bytes
		if (mcycle != mc_fetch) begin
			case (group)
				grp_mov_rm, grp_mov_mr: addr_src = as_hl;
				grp_ldax, grp_stax: addr_src = opcode[4] ? as_de : as_bc;
				grp_lda, grp_sta: addr_src = (cycle_idx == 2'd3) ? as_wz : as_pc;
				default: addr_src = as_pc;
			endcase
		end
	end

endmodule

// File: hdl/cpu_ctrl_pkg.sv
//********************
// Shared types, state encodings and register codes of the control section
//********************

package cpu_ctrl_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [2:0] reg_code_t;
	typedef logic [1:0] cycle_idx_t;	// 0 is the opcode fetch
	typedef logic [1:0] plan_len_t;	// Cycles after the fetch
	typedef logic [2:0] plan_kinds_t;	// Bit k set means cycle k+1 writes

	localparam reg_code_t reg_m = 3'd6;	// Memory through HL
	localparam reg_code_t reg_a = 3'd7;

	typedef enum logic [2:0] {
		t_idle,
		t1,
		t2,
		t3,
		t4
	} tstate_e;

	typedef enum logic [1:0] {
		mc_fetch,
		mc_read,
		mc_write,
		mc_halt
	} mcycle_e;

	typedef enum logic [3:0] {
		grp_nop,
		grp_mov_rr,
		grp_mov_rm,
		grp_mov_mr,
		grp_mvi,
		grp_lxi,
		grp_lda,
		grp_sta,
		grp_ldax,
		grp_stax,
		grp_xchg,
		grp_hlt
	} group_e;

	typedef enum logic [2:0] {
		as_pc,
		as_hl,
		as_bc,
		as_de,
		as_wz
	} addr_src_e;

endpackage

// File: hdl/cpu_ctrl_top.sv
//********************
// Control section top level
//********************
`timescale 1ns/1ps

module cpu_ctrl_top (
	input logic phi1,
	input logic reset,
	input cpu_ctrl_pkg::byte_t data_in,
	output logic ale,
	output logic rd_n,
	output logic wr_n,
	output logic s1,
	output logic s0,
	output logic halted,
	output cpu_ctrl_pkg::addr_src_e addr_src,
	output logic reg_rd,
	output logic reg_wr,
	output cpu_ctrl_pkg::reg_code_t rd_sel,
	output cpu_ctrl_pkg::reg_code_t wr_sel,
	output logic pc_inc,
	output logic wz_wr,
	output logic xchg
);
	import cpu_ctrl_pkg::*;

	group_e next_group;
	plan_len_t next_plan_len;
	plan_kinds_t next_plan_kinds;
	mcycle_e mcycle;
	tstate_e tstate;
	cycle_idx_t cycle_idx;
	group_e group;
	byte_t opcode;

	instr_decode instr_decode_inst (
		.data_in(data_in),
		.next_group(next_group),
		.next_plan_len(next_plan_len),
		.next_plan_kinds(next_plan_kinds)
	);

	cycle_sequencer cycle_sequencer_inst (
		.phi1(phi1),
		.reset(reset),
		.next_group(next_group),
		.next_plan_len(next_plan_len),
		.next_plan_kinds(next_plan_kinds),
		.data_in(data_in),
		.mcycle(mcycle),
		.tstate(tstate),
		.cycle_idx(cycle_idx),
		.group(group),
		.opcode(opcode),
		.halted(halted)
	);

	bus_ctrl bus_ctrl_inst (
		.mcycle(mcycle),
		.tstate(tstate),
		.cycle_idx(cycle_idx),
		.group(group),
		.opcode(opcode),
		.ale(ale),
		.rd_n(rd_n),
		.wr_n(wr_n),
		.s1(s1),
		.s0(s0),
		.addr_src(addr_src)
	);

	reg_ctrl reg_ctrl_inst (
		.mcycle(mcycle),
		.tstate(tstate),
		.cycle_idx(cycle_idx),
		.group(group),
		.opcode(opcode),
		.reg_rd(reg_rd),
		.reg_wr(reg_wr),
		.rd_sel(rd_sel),
		.wr_sel(wr_sel),
		.pc_inc(pc_inc),
		.wz_wr(wz_wr),
		.xchg(xchg)
	);

endmodule

// File: hdl/cycle_sequencer.sv
//********************
// Machine-cycle and T-state sequencer with instruction latch
//********************
`timescale 1ns/1ps

module cycle_sequencer (
	input logic phi1,
	input logic reset,
	input cpu_ctrl_pkg::group_e next_group,
	input cpu_ctrl_pkg::plan_len_t next_plan_len,
	input cpu_ctrl_pkg::plan_kinds_t next_plan_kinds,
	input cpu_ctrl_pkg::byte_t data_in,
	output cpu_ctrl_pkg::mcycle_e mcycle,
	output cpu_ctrl_pkg::tstate_e tstate,
	output cpu_ctrl_pkg::cycle_idx_t cycle_idx,
	output cpu_ctrl_pkg::group_e group,
	output cpu_ctrl_pkg::byte_t opcode,
	output logic halted
);
	import cpu_ctrl_pkg::*;

	plan_len_t plan_len;
	plan_kinds_t plan_kinds;
	mcycle_e mcycle_nxt;
	tstate_e tstate_nxt;
	cycle_idx_t cycle_idx_nxt;
	logic fetch_t3;
	logic cycle_end;

	assign fetch_t3 = (mcycle == mc_fetch) && (tstate == t3);
	assign halted = (mcycle == mc_halt);

	// Opcode arrives in the last cycle of the read window
	always_ff @(posedge phi1) begin
		if (fetch_t3) begin
			opcode <= data_in;
		end
	end

	always_ff @(posedge phi1) begin
		if (reset) begin
			group <= grp_nop;
			plan_len <= '0;
			plan_kinds <= '0;
		end else if (fetch_t3) begin
			group <= next_group;
			plan_len <= next_plan_len;
			plan_kinds <= next_plan_kinds;
		end
	end

	always_comb begin
		mcycle_nxt = mcycle;
		cycle_idx_nxt = cycle_idx;
		case (tstate)
			t_idle: tstate_nxt = (mcycle == mc_halt) ? t_idle : t1;
			t1: tstate_nxt = t2;
			t2: tstate_nxt = t3;
			t3: tstate_nxt = (mcycle == mc_fetch) ? t4 : t1;
			t4: tstate_nxt = (group == grp_hlt) ? t_idle : t1;
			default: tstate_nxt = t_idle;
		endcase

		cycle_end = (tstate_nxt == t1) && (tstate != t_idle);
		if (tstate == t4 && group == grp_hlt) begin
			mcycle_nxt = mc_halt;	// Only reset leaves this
		end else if (cycle_end) begin
			if (cycle_idx == plan_len) begin
				mcycle_nxt = mc_fetch;
				cycle_idx_nxt = '0;
			end else begin
				mcycle_nxt = plan_kinds[cycle_idx] ? mc_write : mc_read;
				cycle_idx_nxt = cycle_idx + 2'd1;
			end
		end
	end

	always_ff @(posedge phi1) begin
		if (reset) begin
			mcycle <= mc_fetch;
			tstate <= t_idle;
			cycle_idx <= '0;
		end else begin
			mcycle <= mcycle_nxt;
			tstate <= tstate_nxt;
			cycle_idx <= cycle_idx_nxt;
		end
	end

endmodule

// File: hdl/instr_decode.sv
//********************
// Opcode decoder and machine-cycle plan table
//********************
`timescale 1ns/1ps

module instr_decode (
	input cpu_ctrl_pkg::byte_t data_in,
	output cpu_ctrl_pkg::group_e next_group,
	output cpu_ctrl_pkg::plan_len_t next_plan_len,
	output cpu_ctrl_pkg::plan_kinds_t next_plan_kinds
);
	import cpu_ctrl_pkg::*;

	reg_code_t dst_code;
	reg_code_t src_code;
	logic [1:0] rp_code;

	assign dst_code = data_in[5:3];
	assign src_code = data_in[2:0];
	assign rp_code = data_in[5:4];

	always_comb begin
		next_group = grp_nop;	// Unknown opcodes fetch and move on
		if (data_in == 8'h76) begin
			next_group = grp_hlt;	// Would be MOV M,M
		end else if (data_in[7:6] == 2'b01) begin
			if (dst_code == reg_m) begin
				next_group = grp_mov_mr;
			end else if (src_code == reg_m) begin
				next_group = grp_mov_rm;
			end else begin
				next_group = grp_mov_rr;
			end
		end else if (data_in == 8'heb) begin
			next_group = grp_xchg;
		end else if (data_in == 8'h3a) begin
			next_group = grp_lda;
		end else if (data_in == 8'h32) begin
			next_group = grp_sta;
		end else if (data_in[7:6] == 2'b00) begin
			if (src_code == 3'b110 && dst_code != reg_m) begin
				next_group = grp_mvi;
			end else if (data_in[3:0] == 4'b0001 && rp_code != 2'b11) begin
				next_group = grp_lxi;	// BC, DE, HL only
			end else if (data_in[5] == 1'b0 && data_in[3:0] == 4'b1010) begin
				next_group = grp_ldax;
			end else if (data_in[5] == 1'b0 && data_in[3:0] == 4'b0010) begin
				next_group = grp_stax;
			end
		end
	end

	// Cycles following the fetch
	always_comb begin
		case (next_group)
			grp_mvi, grp_mov_rm, grp_ldax: begin
				next_plan_len = 2'd1;
				next_plan_kinds = 3'b000;
			end
			grp_mov_mr, grp_stax: begin
				next_plan_len = 2'd1;
				next_plan_kinds = 3'b001;
			end
			grp_lxi: begin
				next_plan_len = 2'd2;
				next_plan_kinds = 3'b000;
			end
			grp_lda: begin
				next_plan_len = 2'd3;
				next_plan_kinds = 3'b000;
			end
			grp_sta: begin
				next_plan_len = 2'd3;
				next_plan_kinds = 3'b100;	// Address low, address high, then store
			end
			default: begin
				next_plan_len = 2'd0;
				next_plan_kinds = 3'b000;
			end
		endcase
	end

endmodule

// File: hdl/reg_ctrl.sv
//********************
// Register-file, WZ, program counter and exchange strobes
//********************
`timescale 1ns/1ps

module reg_ctrl (
	input cpu_ctrl_pkg::mcycle_e mcycle,
	input cpu_ctrl_pkg::tstate_e tstate,
	input cpu_ctrl_pkg::cycle_idx_t cycle_idx,
	input cpu_ctrl_pkg::group_e group,
	input cpu_ctrl_pkg::byte_t opcode,
	output logic reg_rd,
	output logic reg_wr,
	output cpu_ctrl_pkg::reg_code_t rd_sel,
	output cpu_ctrl_pkg::reg_code_t wr_sel,
	output logic pc_inc,
	output logic wz_wr,
	output logic xchg
);
	import cpu_ctrl_pkg::*;

	logic fetch_t4;
	logic read_t3;
	logic write_t2;
	logic direct_addr;
	logic pc_cycle;

	assign fetch_t4 = (mcycle == mc_fetch) && (tstate == t4);
	assign read_t3 = (mcycle == mc_read) && (tstate == t3);
	assign write_t2 = (mcycle == mc_write) && (tstate == t2);

	// LDA/STA address bytes, not the final WZ cycle
	assign direct_addr = (group == grp_lda || group == grp_sta) && (cycle_idx != 2'd3);

	// Same source rule as the bus side
	assign pc_cycle = (mcycle == mc_fetch) ||
		(mcycle == mc_read && (group == grp_mvi || group == grp_lxi || direct_addr));
	assign pc_inc = pc_cycle && (tstate == t3);

	assign reg_rd = (fetch_t4 && group == grp_mov_rr) ||
		(write_t2 && (group == grp_mov_mr || group == grp_sta || group == grp_stax));

	assign reg_wr = (fetch_t4 && group == grp_mov_rr) ||
		(read_t3 && (group == grp_mvi || group == grp_mov_rm || group == grp_lxi)) ||
		(read_t3 && group == grp_ldax) ||
		(read_t3 && group == grp_lda && cycle_idx == 2'd3);

	assign wz_wr = read_t3 && direct_addr;
	assign xchg = fetch_t4 && (group == grp_xchg);

	always_comb begin
		case (group)
			grp_mov_rr, grp_mov_mr: rd_sel = opcode[2:0];	// SSS
			default: rd_sel = reg_a;
		endcase
	end

	always_comb begin
		case (group)
			grp_mov_rr, grp_mov_rm, grp_mvi: wr_sel = opcode[5:3];	// DDD
			grp_lxi: wr_sel = {opcode[5:4], (cycle_idx == 2'd1)};	// Low byte first
			default: wr_sel = reg_a;
		endcase
	end

endmodule

// File: sources.f
hdl/cpu_ctrl_pkg.sv
hdl/instr_decode.sv
hdl/cycle_sequencer.sv
hdl/bus_ctrl.sv
hdl/reg_ctrl.sv
hdl/cpu_ctrl_top.sv
test/cpu_ctrl_assert.sv
test/cpu_ctrl_checker.sv
test/cpu_ctrl_tb.sv

// File: test/cpu_ctrl_assert.sv
//********************
// Concurrent assertions on the bus strobes
//********************
`timescale 1ns/1ps

module cpu_ctrl_assert (
	input logic phi1,
	input logic reset,
	input logic ale,
	input logic rd_n,
	input logic wr_n,
	input logic halted,
	input logic reg_rd,
	input logic reg_wr,
	input logic pc_inc,
	input logic wz_wr,
	input logic xchg
);
	int fail_cnt = 0;

	rd_wr_exclusive: assert property (@(posedge phi1) disable iff (reset) !(!rd_n && !wr_n))
		else begin $error("rd_n and wr_n low together"); fail_cnt++; end

	ale_single: assert property (@(posedge phi1) disable iff (reset) ale |=> !ale)
		else begin $error("ale high for two cycles"); fail_cnt++; end

	halt_quiet: assert property (@(posedge phi1) disable iff (reset) halted |-> !ale)
		else begin $error("ale while halted"); fail_cnt++; end

	// Outputs settle one clock into reset
	reset_idle: assert property (@(posedge phi1) reset && $past(reset) |->
		!ale && rd_n && wr_n && !reg_rd && !reg_wr && !pc_inc && !wz_wr && !xchg)
		else begin $error("strobe active during reset"); fail_cnt++; end

endmodule

// File: test/cpu_ctrl_checker.sv
//********************
// Bus and register activity monitor with reference model
//********************
`timescale 1ns/1ps

module cpu_ctrl_checker (
	input logic phi1,
	input logic reset,
	input logic ale,
	input logic rd_n,
	input logic wr_n,
	input logic s1,
	input logic s0,
	input logic halted,
	input cpu_ctrl_pkg::addr_src_e addr_src,
	input logic reg_rd,
	input logic reg_wr,
	input cpu_ctrl_pkg::reg_code_t rd_sel,
	input cpu_ctrl_pkg::reg_code_t wr_sel,
	input logic pc_inc,
	input logic wz_wr,
	input logic xchg
);
	import cpu_ctrl_pkg::*;

	logic [1:0] e_st [4];	// Status per machine cycle
	addr_src_e e_src [4];
	logic e_rd [4], e_wr [4], e_wz [4], e_xc [4], e_pc [4];
	reg_code_t e_rds [4], e_wrs [4];
	logic e_halt;
	int ncyc, len, k, t, gap, ptr, pc_cnt;
	int errors = 0;
	int ins_cnt = 0;
	logic started = 0;
	logic first = 0;
	logic halt_exp = 0;

	task automatic check_val(input string name, input logic [7:0] act_v, input logic [7:0] exp_v);
		if (act_v !== exp_v) begin
			$display("[FAIL] %s expected %h got %h at %0t", name, exp_v, act_v, $time);
			errors++;
		end
	endtask

	task automatic report(input string msg);
		$display("ERROR: %s at %0t", msg, $time);
		errors++;
	endtask

	function automatic void add_cyc(input logic [1:0] st, input addr_src_e src, input logic pc);
		e_st[ncyc] = st;
		e_src[ncyc] = src;
		e_pc[ncyc] = pc;
		ncyc++;
	endfunction

	// Expected machine cycles and strobes of one opcode, returns its length in bytes
	function automatic int ref_plan(input byte_t op);
		reg_code_t d;
		reg_code_t s;
		d = op[5:3];
		s = op[2:0];
		for (int i = 0; i < 4; i++) begin
			e_rd[i] = 0;
			e_wr[i] = 0;
			e_wz[i] = 0;
			e_xc[i] = 0;
			e_pc[i] = 0;
		end
		ncyc = 0;
		e_halt = 0;
		add_cyc(2'b11, as_pc, 1'b1);
		if (op == 8'h76) begin
			e_halt = 1;
			return 1;
		end
		if (op[7:6] == 2'b01) begin
			if (d == reg_m) begin
				add_cyc(2'b01, as_hl, 1'b0);
				e_rd[1] = 1;
				e_rds[1] = s;
			end else if (s == reg_m) begin
				add_cyc(2'b10, as_hl, 1'b0);
				e_wr[1] = 1;
				e_wrs[1] = d;
			end else begin
				e_rd[0] = 1;
				e_rds[0] = s;
				e_wr[0] = 1;
				e_wrs[0] = d;
			end
			return 1;
		end
		if (op == 8'heb) begin
			e_xc[0] = 1;
			return 1;
		end
		if (op == 8'h3a || op == 8'h32) begin
			add_cyc(2'b10, as_pc, 1'b1);
			add_cyc(2'b10, as_pc, 1'b1);
			e_wz[1] = 1;
			e_wz[2] = 1;
			if (op == 8'h3a) begin
				add_cyc(2'b10, as_wz, 1'b0);
				e_wr[3] = 1;
				e_wrs[3] = reg_a;
			end else begin
				add_cyc(2'b01, as_wz, 1'b0);
				e_rd[3] = 1;
				e_rds[3] = reg_a;
			end
			return 3;
		end
		if (op[7:6] == 2'b00) begin
			if (s == 3'b110 && d != reg_m) begin	// MVI
				add_cyc(2'b10, as_pc, 1'b1);
				e_wr[1] = 1;
				e_wrs[1] = d;
				return 2;
			end
			if (op[3:0] == 4'h1 && op[5:4] != 2'b11) begin	// LXI, low register first
				add_cyc(2'b10, as_pc, 1'b1);
				add_cyc(2'b10, as_pc, 1'b1);
				e_wr[1] = 1;
				e_wrs[1] = {op[5:4], 1'b1};
				e_wr[2] = 1;
				e_wrs[2] = {op[5:4], 1'b0};
				return 3;
			end
			if (!op[5] && (op[3:0] == 4'ha || op[3:0] == 4'h2)) begin
				if (op[3]) begin
					add_cyc(2'b10, op[4] ? as_de : as_bc, 1'b0);
					e_wr[1] = 1;
					e_wrs[1] = reg_a;
				end else begin
					add_cyc(2'b01, op[4] ? as_de : as_bc, 1'b0);
					e_rd[1] = 1;
					e_rds[1] = reg_a;
				end
				return 1;
			end
		end
		return 1;
	endfunction

	always @(negedge phi1) begin
		if (reset) begin
			check_val("ale", 8'(ale), 8'h00);
			check_val("rd_n", 8'(rd_n), 8'h01);
			check_val("wr_n", 8'(wr_n), 8'h01);
			check_val("status", 8'({s1, s0}), 8'h00);
			check_val("reg_rd", 8'(reg_rd), 8'h00);
			check_val("reg_wr", 8'(reg_wr), 8'h00);
			check_val("pc_inc", 8'(pc_inc), 8'h00);
			check_val("wz_wr", 8'(wz_wr), 8'h00);
			check_val("xchg", 8'(xchg), 8'h00);
			check_val("halted", 8'(halted), 8'h00);
			first = 1;
		end else if (halt_exp) begin
			check_val("halted", 8'(halted), 8'h01);
			check_val("ale", 8'(ale), 8'h00);
			check_val("rd_n", 8'(rd_n), 8'h01);
			check_val("wr_n", 8'(wr_n), 8'h01);
			check_val("status", 8'({s1, s0}), 8'h00);
		end else begin
			if (first && !ale)
				report("no ale in the first cycle after reset");
			first = 0;
			gap++;
			if (ale) begin
				if (started && gap != ((k == 0) ? 4 : 3))
					report($sformatf("%0d clocks between ale pulses", gap));
				if (!started || k == ncyc - 1) begin
					if (started && pc_cnt != len)
						report($sformatf("%0d pc_inc pulses for a %0d-byte instruction",
							pc_cnt, len));
					len = ref_plan(cpu_ctrl_tb.prog[ptr]);
					ptr += len;
					ins_cnt++;
					k = 0;
					pc_cnt = 0;
				end else begin
					k++;
				end
				started = 1;
				gap = 0;
				t = 1;
			end else begin
				t++;
			end
			if (t > ((k == 0) ? 4 : 3))
				report("ale missing at the end of a machine cycle");
			check_val("status", 8'({s1, s0}), 8'(e_st[k]));
			check_val("rd_n", 8'(rd_n), 8'(!((t == 2 || t == 3) && e_st[k] != 2'b01)));
			check_val("wr_n", 8'(wr_n), 8'(!((t == 2 || t == 3) && e_st[k] == 2'b01)));
			if (t <= 3)
				check_val("addr_src", 8'(addr_src), 8'(e_src[k]));
			check_val("reg_rd", 8'(reg_rd), 8'(e_rd[k] && t == ((k == 0) ? 4 : 2)));
			if (reg_rd && e_rd[k])
				check_val("rd_sel", 8'(rd_sel), 8'(e_rds[k]));
			check_val("reg_wr", 8'(reg_wr), 8'(e_wr[k] && t == ((k == 0) ? 4 : 3)));
			if (reg_wr && e_wr[k])
				check_val("wr_sel", 8'(wr_sel), 8'(e_wrs[k]));
			check_val("wz_wr", 8'(wz_wr), 8'(e_wz[k] && t == 3));
			check_val("xchg", 8'(xchg), 8'(e_xc[k] && t == 4));
			check_val("pc_inc", 8'(pc_inc), 8'(e_pc[k] && t == 3));
			check_val("halted", 8'(halted), 8'h00);
			if (pc_inc)
				pc_cnt++;
			if (e_halt && t == 4) begin
				halt_exp = 1;	// Halt holds from the next clock on
				if (pc_cnt != 1)
					report("HLT fetch without a single pc_inc");
			end
		end
	end

endmodule

// File: test/cpu_ctrl_tb.sv
//********************
// Testbench top: clock, reset, program memory and run control
//********************
`timescale 1ns/1ps

bind cpu_ctrl_top cpu_ctrl_assert cpu_ctrl_assert_inst (.*);

module cpu_ctrl_tb;
	import cpu_ctrl_pkg::*;

	logic phi1 = 0;
	logic reset = 1;
	byte_t data_in = '0;
	logic ale, rd_n, wr_n, s1, s0, halted;
	addr_src_e addr_src;
	logic reg_rd, reg_wr, pc_inc, wz_wr, xchg;
	reg_code_t rd_sel, wr_sel;

	byte_t prog [256];
	int prog_len = 0;
	int n_instr = 0;
	int mem_ptr = 0;
	logic rd_phase = 0;
	logic [31:0] rnd;
	int cycles = 0;
	int limit;
	int tb_errors = 0;
	int total;

	cpu_ctrl_top cpu_ctrl_top_inst (.*);
	cpu_ctrl_checker cpu_ctrl_checker_inst (.*);

	always #10 phi1 = ~phi1;

	task automatic put(input byte_t b);
		prog[prog_len] = b;
		prog_len++;
	endtask

	task automatic add_random_instr;
		logic [31:0] r;
		reg_code_t d;
		reg_code_t s;
		r = $urandom;
		d = r[2:0];
		s = r[5:3];
		n_instr++;
		case (r[27:24] % 9)
			0: put({2'b01, d, (d == reg_m && s == reg_m) ? reg_a : s});	// Keep clear of HLT
			1: begin
				put({2'b00, (d == reg_m) ? reg_a : d, 3'b110});
				put(r[15:8]);
			end
			2: begin
				put({2'b00, (r[7:6] == 2'b11) ? 2'b10 : r[7:6], 4'b0001});
				put(r[15:8]);
				put(r[23:16]);
			end
			3, 4: begin
				put(r[24] ? 8'h3a : 8'h32);
				put(r[15:8]);
				put(r[23:16]);
			end
			5: put({3'b000, r[8], 4'b1010});
			6: put({3'b000, r[8], 4'b0010});
			7: put(8'heb);
			default: put(8'h00);
		endcase
	endtask

	// Program bytes for PC reads, filler data elsewhere
	always @(negedge phi1) begin
		if (!rd_n) begin
			rnd = $urandom;
			if (addr_src == as_pc) begin
				data_in <= (mem_ptr < prog_len) ? prog[mem_ptr] : 8'h00;
				if (rd_phase)
					mem_ptr++;
			end else begin
				data_in <= rnd[7:0];
			end
			rd_phase = !rd_phase;
		end else begin
			rd_phase = 0;
		end
	end

	initial begin
		void'($urandom(88));
		// MOV B,C; MOV A,M; MOV M,B; MVI A; LXI H; LDA; STA; LDAX; STAX; XCHG; NOP
		put(8'h41);
		put(8'h7e);
		put(8'h70);
		put(8'h3e);
		put(8'h5a);
		put(8'h21);
		put(8'h34);
		put(8'h12);
		put(8'h3a);
		put(8'h00);
		put(8'h80);
		put(8'h32);
		put(8'h01);
		put(8'h80);
		put(8'h0a);
		put(8'h1a);
		put(8'h02);
		put(8'h12);
		put(8'heb);
		put(8'h00);
		n_instr = 13;
		repeat (40) add_random_instr();
		put(8'h76);
		n_instr++;
		limit = 12 * n_instr + 50;

		repeat (5) @(negedge phi1);
		reset <= 0;
		while (!halted && cycles < limit) begin
			@(negedge phi1);
			cycles++;
		end
		if (!halted) begin
			$display("ERROR: timeout, no halt after %0d cycles", cycles);
			tb_errors++;
		end else begin
			repeat (20) @(posedge phi1);
			if (cpu_ctrl_checker_inst.ins_cnt != n_instr) begin
				$display("ERROR: %0d of %0d instructions observed",
					cpu_ctrl_checker_inst.ins_cnt, n_instr);
				tb_errors++;
			end
		end
		total = cpu_ctrl_checker_inst.errors + tb_errors +
			cpu_ctrl_top_inst.cpu_ctrl_assert_inst.fail_cnt;
		$display("checker errors %0d, testbench errors %0d, assertion failures %0d",
			cpu_ctrl_checker_inst.errors, tb_errors,
			cpu_ctrl_top_inst.cpu_ctrl_assert_inst.fail_cnt);
		if (total == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
